// File: rtl/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    localparam int data_w = 32;
    localparam int addr_w = 32;
    localparam int be_w   = 4;

    // top address nibble picks the slave
    typedef enum logic [3:0] {
        region_ram  = 4'd0,
        region_uart = 4'd1,
        region_gpio = 4'd2,
        region_none = 4'hf
    } region_e;

    // register offsets inside a slave, low address bits only
    typedef enum logic [3:0] {
        uart_data   = 4'h0,
        uart_status = 4'h4
    } uart_reg_e;

    typedef enum logic [3:0] {
        gpio_out = 4'h0,
        gpio_in  = 4'h4
    } gpio_reg_e;

    localparam int status_tx_ready_bit = 0;
    localparam int status_rx_valid_bit = 1;

    // one frame walk shared by the transmitter and the receiver
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_e;

endpackage

`default_nettype wire

// File: rtl/data_bus_if.sv
`default_nettype none

// one strobe bus link, reads answer one cycle after the strobe
interface data_bus_if;

    logic [soc_bus_pkg::addr_w-1:0] address;
    logic [soc_bus_pkg::be_w-1:0]   byteenable;
    logic                           read;
    logic                           write;
    logic [soc_bus_pkg::data_w-1:0] wrdata;
    logic [soc_bus_pkg::data_w-1:0] rddata;

    modport master (
        output address,
        output byteenable,
        output read,
        output write,
        output wrdata,
        input  rddata
    );

    modport slave (
        input  address,
        input  byteenable,
        input  read,
        input  write,
        input  wrdata,
        output rddata
    );

endinterface

`default_nettype wire

// File: rtl/dbus.sv
`default_nettype none

module dbus (
    input  wire                             clk,
    input  wire                             reset_i,
    input  wire [soc_bus_pkg::addr_w-1:0]   master_address_i,
    input  wire [soc_bus_pkg::be_w-1:0]     master_byteenable_i,
    input  wire                             master_read_i,
    input  wire                             master_write_i,
    input  wire [soc_bus_pkg::data_w-1:0]   master_wrdata_i,
    output logic [soc_bus_pkg::data_w-1:0]  master_rddata_o,
    data_bus_if.master                      ram_bus,
    data_bus_if.master                      uart_bus,
    data_bus_if.master                      gpio_bus
);

    soc_bus_pkg::region_e region;
    soc_bus_pkg::region_e rd_region_q;
    logic [soc_bus_pkg::addr_w-1:0] slave_address;

    always_comb begin
        case (master_address_i[soc_bus_pkg::addr_w-1 -: 4])
            4'd0:    region = soc_bus_pkg::region_ram;
            4'd1:    region = soc_bus_pkg::region_uart;
            4'd2:    region = soc_bus_pkg::region_gpio;
            default: region = soc_bus_pkg::region_none;
        endcase
    end

    // slaves see only their local address space
    assign slave_address = {4'b0000, master_address_i[soc_bus_pkg::addr_w-5:0]};

    assign ram_bus.address     = slave_address;
    assign ram_bus.byteenable  = master_byteenable_i;
    assign ram_bus.wrdata      = master_wrdata_i;
    assign ram_bus.read        = master_read_i && (region == soc_bus_pkg::region_ram);
    assign ram_bus.write       = master_write_i && (region == soc_bus_pkg::region_ram);

    assign uart_bus.address    = slave_address;
    assign uart_bus.byteenable = master_byteenable_i;
    assign uart_bus.wrdata     = master_wrdata_i;
    assign uart_bus.read       = master_read_i && (region == soc_bus_pkg::region_uart);
    assign uart_bus.write      = master_write_i && (region == soc_bus_pkg::region_uart);

    assign gpio_bus.address    = slave_address;
    assign gpio_bus.byteenable = master_byteenable_i;
    assign gpio_bus.wrdata     = master_wrdata_i;
    assign gpio_bus.read       = master_read_i && (region == soc_bus_pkg::region_gpio);
    assign gpio_bus.write      = master_write_i && (region == soc_bus_pkg::region_gpio);

    // a cycle without a read falls back to none, so stale slave data never shows
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_region_q <= soc_bus_pkg::region_none;
        end else if (master_read_i) begin
            rd_region_q <= region;
        end else begin
            rd_region_q <= soc_bus_pkg::region_none;
        end
    end

    always_comb begin
        case (rd_region_q)
            soc_bus_pkg::region_ram:  master_rddata_o = ram_bus.rddata;
            soc_bus_pkg::region_uart: master_rddata_o = uart_bus.rddata;
            soc_bus_pkg::region_gpio: master_rddata_o = gpio_bus.rddata;
            default:                  master_rddata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int ram_words = 256
) (
    input  wire         clk,
    data_bus_if.slave   bus
);

    localparam int idx_w = $clog2(ram_words);

    logic [soc_bus_pkg::data_w-1:0] mem [ram_words];
    logic [idx_w-1:0]               word_idx;

    // upper address bits are dropped, so the array repeats through the region
    assign word_idx = bus.address[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int i = 0; i < soc_bus_pkg::be_w; i++) begin
                if (bus.byteenable[i]) begin
                    mem[word_idx][8*i +: 8] <= bus.wrdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.rddata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: rtl/gpio_top.sv
`default_nettype none

module gpio_top (
    input  wire                             clk,
    input  wire                             reset_i,
    input  wire [soc_bus_pkg::data_w-1:0]   gpio1_i,
    output logic [soc_bus_pkg::data_w-1:0]  gpio0_o,
    data_bus_if.slave                       bus
);

    logic [soc_bus_pkg::data_w-1:0] out_q;
    logic [soc_bus_pkg::data_w-1:0] in_meta_q;
    logic [soc_bus_pkg::data_w-1:0] in_sync_q;
    logic                           sel_out;
    logic                           sel_in;

    assign sel_out = (bus.address[3:0] == soc_bus_pkg::gpio_out);
    assign sel_in  = (bus.address[3:0] == soc_bus_pkg::gpio_in);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (bus.write && sel_out) begin
            for (int i = 0; i < soc_bus_pkg::be_w; i++) begin
                if (bus.byteenable[i]) begin
                    out_q[8*i +: 8] <= bus.wrdata[8*i +: 8];
                end
            end
        end
    end

    assign gpio0_o = out_q;

    // input pins are asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio1_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.read) begin
            if (sel_out) begin
                bus.rddata <= out_q;
            end else if (sel_in) begin
                bus.rddata <= in_sync_q;
            end else begin
                bus.rddata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`default_nettype none

module uart_top #(
    parameter int clks_per_bit = 16
) (
    input  wire         clk,
    input  wire         reset_i,
    input  wire         rxd_i,
    output logic        txd_o,
    data_bus_if.slave   bus
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    soc_bus_pkg::uart_state_e tx_state_q;
    logic [7:0]               tx_shift_q;
    logic [2:0]               tx_bit_q;
    logic [cnt_w-1:0]         tx_cnt_q;
    logic                     txd_q;
    logic                     tx_ready;
    logic                     tx_start;

    soc_bus_pkg::uart_state_e rx_state_q;
    logic                     rx_meta_q;
    logic                     rx_sync_q;
    logic [7:0]               rx_shift_q;
    logic [2:0]               rx_bit_q;
    logic [cnt_w-1:0]         rx_cnt_q;
    logic [7:0]               rx_data_q;
    logic                     rx_valid_q;

    logic                     sel_data;
    logic                     sel_status;

    assign sel_data   = (bus.address[3:0] == soc_bus_pkg::uart_data);
    assign sel_status = (bus.address[3:0] == soc_bus_pkg::uart_status);
    assign tx_ready   = (tx_state_q == soc_bus_pkg::st_idle);
    // a write while busy is simply not seen by the transmitter
    assign tx_start   = bus.write && sel_data && tx_ready;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_state_q <= soc_bus_pkg::st_idle;
            tx_bit_q   <= '0;
            tx_cnt_q   <= '0;
            txd_q      <= 1'b1;
        end else begin
            case (tx_state_q)
                soc_bus_pkg::st_idle: begin
                    if (tx_start) begin
                        tx_state_q <= soc_bus_pkg::st_start;
                        tx_shift_q <= bus.wrdata[7:0];
                        tx_cnt_q   <= '0;
                        txd_q      <= 1'b0;
                    end
                end
                soc_bus_pkg::st_start: begin
                    if (tx_cnt_q == bit_last) begin
                        tx_state_q <= soc_bus_pkg::st_data;
                        tx_cnt_q   <= '0;
                        tx_bit_q   <= '0;
                        txd_q      <= tx_shift_q[0];
                        tx_shift_q <= tx_shift_q >> 1;
                    end else begin
                        tx_cnt_q <= tx_cnt_q + 1'b1;
                    end
                end
                soc_bus_pkg::st_data: begin
                    if (tx_cnt_q == bit_last) begin
                        tx_cnt_q <= '0;
                        if (tx_bit_q == 3'd7) begin
                            tx_state_q <= soc_bus_pkg::st_stop;
                            txd_q      <= 1'b1;
                        end else begin
                            tx_bit_q   <= tx_bit_q + 1'b1;
                            txd_q      <= tx_shift_q[0];
                            tx_shift_q <= tx_shift_q >> 1;
                        end
                    end else begin
                        tx_cnt_q <= tx_cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (tx_cnt_q == bit_last) begin
                        tx_state_q <= soc_bus_pkg::st_idle;
                        tx_cnt_q   <= '0;
                    end else begin
                        tx_cnt_q <= tx_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    assign txd_o = txd_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rxd_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    // the start state waits half a bit so later samples land mid-bit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_state_q <= soc_bus_pkg::st_idle;
            rx_bit_q   <= '0;
            rx_cnt_q   <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            if (bus.read && sel_data) begin
                rx_valid_q <= 1'b0;
            end
            case (rx_state_q)
                soc_bus_pkg::st_idle: begin
                    if (!rx_sync_q) begin
                        rx_state_q <= soc_bus_pkg::st_start;
                        rx_cnt_q   <= '0;
                    end
                end
                soc_bus_pkg::st_start: begin
                    if (rx_cnt_q == half_last) begin
                        rx_cnt_q   <= '0;
                        rx_bit_q   <= '0;
                        rx_state_q <= rx_sync_q ? soc_bus_pkg::st_idle : soc_bus_pkg::st_data;
                    end else begin
                        rx_cnt_q <= rx_cnt_q + 1'b1;
                    end
                end
                soc_bus_pkg::st_data: begin
                    if (rx_cnt_q == bit_last) begin
                        rx_cnt_q   <= '0;
                        rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
                        if (rx_bit_q == 3'd7) begin
                            rx_state_q <= soc_bus_pkg::st_stop;
                        end else begin
                            rx_bit_q <= rx_bit_q + 1'b1;
                        end
                    end else begin
                        rx_cnt_q <= rx_cnt_q + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt_q == bit_last) begin
                        rx_cnt_q   <= '0;
                        rx_state_q <= soc_bus_pkg::st_idle;
                        // a frame with a bad stop bit is discarded
                        if (rx_sync_q) begin
                            rx_data_q  <= rx_shift_q;
                            rx_valid_q <= 1'b1;
                        end
                    end else begin
                        rx_cnt_q <= rx_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.rddata <= '0;
            if (sel_data) begin
                bus.rddata[7:0] <= rx_data_q;
            end else if (sel_status) begin
                bus.rddata[soc_bus_pkg::status_tx_ready_bit] <= tx_ready;
                bus.rddata[soc_bus_pkg::status_rx_valid_bit] <= rx_valid_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/soc_dbus_top.sv
`default_nettype none

module soc_dbus_top #(
    parameter int clks_per_bit = 16,
    parameter int ram_words    = 1024
) (
    input  wire                             clk,
    input  wire                             reset_i,
    input  wire [soc_bus_pkg::addr_w-1:0]   bus_address_i,
    input  wire [soc_bus_pkg::be_w-1:0]     bus_byteenable_i,
    input  wire                             bus_read_i,
    input  wire                             bus_write_i,
    input  wire [soc_bus_pkg::data_w-1:0]   bus_wrdata_i,
    output logic [soc_bus_pkg::data_w-1:0]  bus_rddata_o,
    input  wire                             rxd_i,
    output logic                            txd_o,
    input  wire [soc_bus_pkg::data_w-1:0]   gpio1_i,
    output logic [soc_bus_pkg::data_w-1:0]  gpio0_o
);

    data_bus_if ram_bus ();
    data_bus_if uart_bus ();
    data_bus_if gpio_bus ();

    dbus dbus0 (
        .clk                 (clk),
        .reset_i             (reset_i),
        .master_address_i    (bus_address_i),
        .master_byteenable_i (bus_byteenable_i),
        .master_read_i       (bus_read_i),
        .master_write_i      (bus_write_i),
        .master_wrdata_i     (bus_wrdata_i),
        .master_rddata_o     (bus_rddata_o),
        .ram_bus             (ram_bus),
        .uart_bus            (uart_bus),
        .gpio_bus            (gpio_bus)
    );

    data_ram #(
        .ram_words (ram_words)
    ) mainram (
        .clk (clk),
        .bus (ram_bus)
    );

    uart_top #(
        .clks_per_bit (clks_per_bit)
    ) uart0 (
        .clk     (clk),
        .reset_i (reset_i),
        .rxd_i   (rxd_i),
        .txd_o   (txd_o),
        .bus     (uart_bus)
    );

    gpio_top gpio_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .gpio1_i (gpio1_i),
        .gpio0_o (gpio0_o),
        .bus     (gpio_bus)
    );

endmodule

`default_nettype wire

// File: testbench/tb_soc_dbus_top.sv
`default_nettype none

module tb_soc_dbus_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] uart_data_addr   = 32'h1000_0000;
    localparam logic [31:0] uart_status_addr = 32'h1000_0004;
    localparam logic [31:0] gpio_out_addr    = 32'h2000_0000;
    localparam logic [31:0] gpio_in_addr     = 32'h2000_0004;

    logic        clk;
    logic        reset_i;
    logic [31:0] bus_address_i;
    logic [3:0]  bus_byteenable_i;
    logic        bus_read_i;
    logic        bus_write_i;
    logic [31:0] bus_wrdata_i;
    logic [31:0] bus_rddata_o;
    logic [31:0] gpio1_i;
    logic [31:0] gpio0_o;
    wire         txd_o;

    logic [31:0] ram_model [256];
    logic [31:0] gpio_model;
    logic        pend_rd;
    logic        pend_chk;
    logic [31:0] pend_exp;
    logic [31:0] last_rd;
    string       pend_name;
    int          errors = 0;
    int          checks = 0;

    // txd_o loops straight back into the receiver
    soc_dbus_top #(
        .clks_per_bit (8),
        .ram_words    (256)
    ) DUT (
        .clk              (clk),
        .reset_i          (reset_i),
        .bus_address_i    (bus_address_i),
        .bus_byteenable_i (bus_byteenable_i),
        .bus_read_i       (bus_read_i),
        .bus_write_i      (bus_write_i),
        .bus_wrdata_i     (bus_wrdata_i),
        .bus_rddata_o     (bus_rddata_o),
        .rxd_i            (txd_o),
        .txd_o            (txd_o),
        .gpio1_i          (gpio1_i),
        .gpio0_o          (gpio0_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int l = 0; l < 4; l++) begin
            if (be[l]) begin
                res[8*l +: 8] = data[8*l +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    // one bus cycle, the read issued in the previous cycle is answered now
    task automatic bus_cycle(input logic rd, input logic wr, input logic [31:0] addr,
                             input logic [3:0] be, input logic [31:0] data,
                             input logic chk, input logic [31:0] exp);
        @(negedge clk);
        if (pend_rd) begin
            last_rd = bus_rddata_o;
            if (pend_chk) begin
                check(pend_name, bus_rddata_o, pend_exp);
            end
        end
        bus_read_i       = rd;
        bus_write_i      = wr;
        bus_address_i    = addr;
        bus_byteenable_i = be;
        bus_wrdata_i     = data;
        pend_rd          = rd;
        pend_chk         = chk;
        pend_exp         = exp;
        pend_name        = $sformatf("bus_rddata_o@%08h", addr);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) bus_cycle(1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        bus_cycle(1'b0, 1'b1, addr, be, data, 1'b0, 32'h0);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp);
        bus_cycle(1'b1, 1'b0, addr, 4'hf, 32'h0, 1'b1, exp);
    endtask

    task automatic read_value(input logic [31:0] addr, output logic [31:0] data);
        bus_cycle(1'b1, 1'b0, addr, 4'hf, 32'h0, 1'b0, 32'h0);
        idle_cycles(1);
        data = last_rd;
    endtask

    task automatic ram_write(input logic [31:0] addr, input logic [3:0] be, input logic [31:0] data);
        write_word(addr, be, data);
        ram_model[addr[9:2]] = merge_lanes(ram_model[addr[9:2]], data, be);
    endtask

    task automatic wait_status(input int bit_idx, output logic ok);
        logic [31:0] st;
        ok = 1'b0;
        for (int n = 0; n < 400 && !ok; n++) begin
            read_value(uart_status_addr, st);
            ok = st[bit_idx];
        end
        if (!ok) begin
            errors++;
            $display("timeout: UART status bit %0d never became 1", bit_idx);
        end
    endtask

    task automatic uart_frame(input logic [7:0] b);
        logic ok;
        wait_status(0, ok);
        write_word(uart_data_addr, 4'h1, {24'h0, b});
        ok = 1'b0;
        for (int n = 0; n < 40 && !ok; n++) begin
            idle_cycles(1);
            ok = !txd_o;
        end
        if (!ok) begin
            errors++;
            $display("timeout: no start bit on txd_o after the data write");
        end
        // detection is half a cycle into the start bit, mid-bit is 3 cycles later
        idle_cycles(3);
        check("txd_o start bit", 32'(txd_o), 32'h0);
        for (int k = 0; k < 8; k++) begin
            if (k == 0) begin
                write_word(uart_data_addr, 4'h1, {24'h0, ~b});
                idle_cycles(7);
            end else begin
                idle_cycles(8);
            end
            check($sformatf("txd_o data bit %0d", k), 32'(txd_o), 32'(b[k]));
        end
        idle_cycles(8);
        check("txd_o stop bit", 32'(txd_o), 32'h1);
        // the write during the frame was dropped, so the line stays idle
        for (int n = 0; n < 24; n++) begin
            idle_cycles(1);
            check("txd_o idle", 32'(txd_o), 32'h1);
        end
        wait_status(1, ok);
        read_expect(uart_data_addr, {24'h0, b});
        read_expect(uart_status_addr, 32'h1);
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] raddr;
        logic [31:0] gval;
        int          nrd;
        void'($urandom(6956));
        reset_i          = 1'b1;
        bus_address_i    = '0;
        bus_byteenable_i = '0;
        bus_read_i       = 1'b0;
        bus_write_i      = 1'b0;
        bus_wrdata_i     = '0;
        gpio1_i          = '0;
        gpio_model       = '0;
        pend_rd          = 1'b0;
        pend_chk         = 1'b0;
        pend_exp         = '0;
        last_rd          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        check("txd_o", 32'(txd_o), 32'h1);
        check("gpio0_o", gpio0_o, 32'h0);
        read_expect(uart_status_addr, 32'h1);

        for (int i = 0; i < 256; i++) begin
            addr = {22'h0, i[7:0], 2'b00};
            ram_write(addr, 4'hf, fill_word(addr));
        end
        for (int i = 0; i < 300; i++) begin
            addr = {4'h0, 26'($urandom()), 2'b00};
            ram_write(addr, 4'($urandom()), $urandom());
            nrd = $urandom_range(3, 0);
            for (int j = 0; j < nrd; j++) begin
                // the first read hits the same word through an alias
                if (j == 0) begin
                    raddr = {4'h0, 18'($urandom()), addr[9:0]};
                end else begin
                    raddr = {4'h0, 26'($urandom()), 2'b00};
                end
                read_expect(raddr, ram_model[raddr[9:2]]);
            end
        end

        for (int i = 0; i < 16; i++) begin
            gval = $urandom();
            write_word(gpio_out_addr, 4'($urandom()) | 4'(i == 0 ? 4'hf : 4'h0), gval);
            gpio_model = merge_lanes(gpio_model, gval, bus_byteenable_i);
            read_expect(gpio_out_addr, gpio_model);
            check("gpio0_o", gpio0_o, gpio_model);
        end
        for (int i = 0; i < 8; i++) begin
            idle_cycles(1);
            gval = $urandom();
            gpio1_i = gval;
            idle_cycles(1);
            read_expect(gpio_in_addr, gval);
        end

        for (int i = 0; i < 4; i++) begin
            uart_frame(8'($urandom()));
        end

        for (int i = 0; i < 24; i++) begin
            raddr = {4'h0, 26'($urandom()), 2'b00};
            addr = {4'($urandom_range(15, 3)), raddr[27:0]};
            read_expect(addr, 32'h0);
            write_word(addr, 4'hf, $urandom());
            read_expect(raddr, ram_model[raddr[9:2]]);
        end
        read_expect(gpio_out_addr, gpio_model);
        read_expect(uart_status_addr, 32'h1);
        idle_cycles(2);
        check("gpio0_o", gpio0_o, gpio_model);
        check("txd_o", 32'(txd_o), 32'h1);

        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_dbus_top.f
rtl/soc_bus_pkg.sv
rtl/data_bus_if.sv
rtl/dbus.sv
rtl/data_ram.sv
rtl/gpio_top.sv
rtl/uart_top.sv
rtl/soc_dbus_top.sv
testbench/tb_soc_dbus_top.sv

// File: Makefile
# Verilator build and run of the data-bus testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/tb_sim: soc_dbus_top.f $(wildcard rtl/*.sv) testbench/tb_soc_dbus_top.sv
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module tb_soc_dbus_top -f soc_dbus_top.f -o tb_sim

test: obj_dir/tb_sim
	obj_dir/tb_sim | tee sim.log
	@if grep -q "^>>> PASS$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
